// ==== design/serv_config.svh ====
`ifndef SERV_CONFIG_SVH
`define SERV_CONFIG_SVH

// Architectural register width, also the run length in cycles
`define SERV_XLEN 32

// Register file address width
`define SERV_REG_AW 5

// Bit counter width, counts 0 to SERV_XLEN-1
`define SERV_CNT_W 5

// First fetch address after reset
`define SERV_RESET_PC 32'h0000_0000

`endif

// ==== design/serv_isa_pkg.sv ====
`include "serv_config.svh"

package serv_isa_pkg;

   // Major opcode, instruction bits 6:2
   typedef enum logic [4:0] {
      OP_IMM = 5'b00100,
      OP     = 5'b01100,
      LUI    = 5'b01101
   } opcode_e;

   typedef enum logic [2:0] {
      ADD_SUB = 3'b000,
      XOR     = 3'b100,
      OR      = 3'b110,
      AND     = 3'b111
   } funct3_e;

   typedef struct packed {
      logic [6:0]              funct7;
      logic [`SERV_REG_AW-1:0] rs2;
      logic [`SERV_REG_AW-1:0] rs1;
      funct3_e                 funct3;
      logic [`SERV_REG_AW-1:0] rd;
      opcode_e                 opcode;
      logic [1:0]              low;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0]             imm;
      logic [`SERV_REG_AW-1:0] rs1;
      funct3_e                 funct3;
      logic [`SERV_REG_AW-1:0] rd;
      opcode_e                 opcode;
      logic [1:0]              low;
   } i_fmt_t;

   // Same fetched word, read as R-type or as I-type
   typedef union packed {
      r_fmt_t r_fmt;
      i_fmt_t i_fmt;
   } instr_u;

endpackage

// ==== design/serv_core_pkg.sv ====
`include "serv_config.svh"

package serv_core_pkg;

   // Subtraction is carried on a separate flag
   typedef enum logic [1:0] {
      ADD = 2'd0,
      XOR = 2'd1,
      OR  = 2'd2,
      AND = 2'd3
   } alu_op_e;

   typedef enum logic [1:0] {
      FETCH = 2'd0,
      RREQ  = 2'd1,
      RUN   = 2'd2
   } seq_state_e;

   // Program counter, held as a shift register
   typedef logic [`SERV_XLEN-1:0] pc_t;

endpackage

// ==== design/serv_decode.sv ====
`timescale 1ns/1ps
`include "serv_config.svh"

module serv_decode (
   input  wire                           i_clk,
   input  wire                           i_rst_n,
   input  wire                           i_capture,
   input  wire  [`SERV_XLEN-1:0]         i_instr,
   input  wire                           i_cnt_en,
   output logic [`SERV_REG_AW-1:0]       o_rreg0,
   output logic [`SERV_REG_AW-1:0]       o_rreg1,
   output logic [`SERV_REG_AW-1:0]       o_rd,
   output serv_core_pkg::alu_op_e        o_alu_op,
   output logic                          o_sub,
   output logic                          o_imm_sel,
   output logic                          o_is_lui,
   output logic                          o_wr_ok,
   output logic                          o_imm_bit
);

   serv_isa_pkg::instr_u  instr;
   serv_isa_pkg::instr_u  cap_word;
   logic [`SERV_XLEN-1:0] imm_load;
   logic [`SERV_XLEN-1:0] imm_sr;
   logic                  f3_ok;
   logic                  supported;

   assign cap_word = i_instr;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         instr <= '0;
      end else if (i_capture) begin
         instr <= i_instr;
      end
   end

   assign o_rreg0 = instr.r_fmt.rs1;
   assign o_rreg1 = instr.r_fmt.rs2;
   assign o_rd    = instr.r_fmt.rd;

   // LUI puts the upper 20 bits above 12 zeros
   assign imm_load = (cap_word.i_fmt.opcode == serv_isa_pkg::LUI) ?
                     {i_instr[`SERV_XLEN-1:12], 12'b0} :
                     {{(`SERV_XLEN-12){cap_word.i_fmt.imm[11]}}, cap_word.i_fmt.imm};

   // LSB first, one bit per run cycle
   always_ff @(posedge i_clk) begin
      if (i_capture) begin
         imm_sr <= imm_load;
      end else if (i_cnt_en) begin
         imm_sr <= {1'b0, imm_sr[`SERV_XLEN-1:1]};
      end
   end

   assign o_imm_bit = imm_sr[0];

   always_comb begin
      f3_ok    = 1'b1;
      o_alu_op = serv_core_pkg::ADD;
      case (instr.r_fmt.funct3)
         serv_isa_pkg::ADD_SUB: o_alu_op = serv_core_pkg::ADD;
         serv_isa_pkg::XOR:     o_alu_op = serv_core_pkg::XOR;
         serv_isa_pkg::OR:      o_alu_op = serv_core_pkg::OR;
         serv_isa_pkg::AND:     o_alu_op = serv_core_pkg::AND;
         default:               f3_ok = 1'b0;
      endcase
   end

   always_comb begin
      supported = 1'b0;
      o_sub     = 1'b0;
      o_imm_sel = 1'b0;
      o_is_lui  = 1'b0;
      case (instr.r_fmt.opcode)
         serv_isa_pkg::OP: begin
            supported = f3_ok;
            o_sub     = (instr.r_fmt.funct3 == serv_isa_pkg::ADD_SUB) & instr.r_fmt.funct7[5];
         end
         serv_isa_pkg::OP_IMM: begin
            supported = f3_ok;
            o_imm_sel = 1'b1;
         end
         serv_isa_pkg::LUI: begin
            supported = 1'b1;
            o_imm_sel = 1'b1;
            o_is_lui  = 1'b1;
         end
         default: supported = 1'b0;
      endcase
   end

   // x0 is never written
   assign o_wr_ok = supported & (instr.r_fmt.rd != '0);

   a_low_bits: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_capture |=> (instr.r_fmt.low == 2'b11));

endmodule

// ==== design/serv_state.sv ====
`timescale 1ns/1ps
`include "serv_config.svh"

module serv_state (
   input  wire  i_clk,
   input  wire  i_rst_n,
   input  wire  i_ibus_ack,
   input  wire  i_rf_ready,
   output logic o_ibus_cyc,
   output logic o_rf_rreq,
   output logic o_cnt_en,
   output logic o_cnt0,
   output logic o_cnt_done,
   output logic o_capture
);

   serv_core_pkg::seq_state_e state;
   logic [`SERV_CNT_W-1:0]    cnt;

   assign o_ibus_cyc = (state == serv_core_pkg::FETCH);
   assign o_rf_rreq  = (state == serv_core_pkg::RREQ);
   assign o_cnt_en   = (state == serv_core_pkg::RUN);
   assign o_cnt0     = o_cnt_en & (cnt == '0);
   assign o_cnt_done = o_cnt_en & (&cnt);

   // Decode takes the word in the ack cycle
   assign o_capture = o_ibus_cyc & i_ibus_ack;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= serv_core_pkg::FETCH;
      end else begin
         case (state)
            serv_core_pkg::FETCH: begin
               if (i_ibus_ack) begin
                  state <= serv_core_pkg::RREQ;
               end
            end
            serv_core_pkg::RREQ: begin
               if (i_rf_ready) begin
                  state <= serv_core_pkg::RUN;
               end
            end
            serv_core_pkg::RUN: begin
               if (o_cnt_done) begin
                  state <= serv_core_pkg::FETCH;
               end
            end
            default: state <= serv_core_pkg::FETCH;
         endcase
      end
   end

   // Wraps back to zero after the last bit
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cnt <= '0;
      end else if (o_cnt_en) begin
         cnt <= cnt + 1'b1;
      end
   end

   a_one_request: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(o_ibus_cyc && o_rf_rreq));

   // Counter rests at zero whenever no run is active
   a_cnt_only_in_run: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !o_cnt_en |-> (cnt == '0));

endmodule

// ==== design/serv_alu.sv ====
`timescale 1ns/1ps

module serv_alu (
   input  wire                    i_clk,
   input  wire                    i_rst_n,
   input  wire                    i_cnt_en,
   input  wire                    i_cnt0,
   input  wire                    i_rs1,
   input  wire                    i_rs2,
   input  wire                    i_imm_bit,
   input  wire serv_core_pkg::alu_op_e i_alu_op,
   input  wire                    i_sub,
   input  wire                    i_imm_sel,
   input  wire                    i_is_lui,
   input  wire                    i_wr_ok,
   output logic                   o_rd_bit,
   output logic                   o_wen
);

   logic op_b;
   logic carry;
   logic carry_in;
   logic carry_out;
   logic sum;
   logic bool_bit;

   assign op_b = (i_imm_sel ? i_imm_bit : i_rs2) ^ i_sub;

   // The +1 of two's complement enters at bit 0
   assign carry_in  = i_cnt0 ? i_sub : carry;
   assign sum       = i_rs1 ^ op_b ^ carry_in;
   assign carry_out = (i_rs1 & op_b) | (carry_in & (i_rs1 ^ op_b));

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry <= 1'b0;
      end else if (i_cnt_en) begin
         carry <= carry_out;
      end
   end

   always_comb begin
      case (i_alu_op)
         serv_core_pkg::XOR: bool_bit = i_rs1 ^ op_b;
         serv_core_pkg::OR:  bool_bit = i_rs1 | op_b;
         serv_core_pkg::AND: bool_bit = i_rs1 & op_b;
         default:            bool_bit = sum;
      endcase
   end

   // LUI writes the immediate untouched
   assign o_rd_bit = i_is_lui ? i_imm_bit : bool_bit;
   assign o_wen    = i_wr_ok & i_cnt_en;

endmodule

// ==== design/serv_ctrl.sv ====
`timescale 1ns/1ps
`include "serv_config.svh"

module serv_ctrl (
   input  wire                  i_clk,
   input  wire                  i_rst_n,
   input  wire                  i_cnt_en,
   input  wire                  i_cnt0,
   output logic [`SERV_XLEN-1:0] o_ibus_adr
);

   serv_core_pkg::pc_t pc;
   logic [1:0]         inc_pos;
   logic               carry;
   logic               add_in;
   logic               pc_bit;

   // Tracks counts 1 and 2, bit 2 is where the 4 goes in
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         inc_pos <= 2'b00;
      end else if (i_cnt_en) begin
         inc_pos <= {inc_pos[0], i_cnt0};
      end
   end

   // Carry out of bit 31 is dropped
   assign add_in = inc_pos[1] | (carry & ~i_cnt0);
   assign pc_bit = pc[0] ^ add_in;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc    <= `SERV_RESET_PC;
         carry <= 1'b0;
      end else if (i_cnt_en) begin
         pc    <= {pc_bit, pc[`SERV_XLEN-1:1]};
         carry <= pc[0] & add_in;
      end
   end

   assign o_ibus_adr = pc;

endmodule

// ==== design/serv_top.sv ====
`timescale 1ns/1ps
`include "serv_config.svh"

module serv_top (
   input  wire                    i_clk,
   input  wire                    i_rst_n,
   input  wire [`SERV_XLEN-1:0]   i_ibus_rdt,
   input  wire                    i_ibus_ack,
   input  wire                    i_rf_ready,
   input  wire                    i_rdata0,
   input  wire                    i_rdata1,
   output wire [`SERV_XLEN-1:0]   o_ibus_adr,
   output wire                    o_ibus_cyc,
   output wire                    o_rf_rreq,
   output wire [`SERV_REG_AW-1:0] o_rreg0,
   output wire [`SERV_REG_AW-1:0] o_rreg1,
   output wire [`SERV_REG_AW-1:0] o_wreg0,
   output wire                    o_wen0,
   output wire                    o_wdata0
);

   wire                    cnt_en;
   wire                    cnt0;
   wire                    capture;
   serv_core_pkg::alu_op_e alu_op;
   wire                    sub;
   wire                    imm_sel;
   wire                    is_lui;
   wire                    wr_ok;
   wire                    imm_bit;

   // Run end is only used inside the sequencer
   serv_state state (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_rf_ready (i_rf_ready),
      .o_ibus_cyc (o_ibus_cyc),
      .o_rf_rreq  (o_rf_rreq),
      .o_cnt_en   (cnt_en),
      .o_cnt0     (cnt0),
      .o_cnt_done (),
      .o_capture  (capture)
   );

   serv_decode decode (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_capture (capture),
      .i_instr   (i_ibus_rdt),
      .i_cnt_en  (cnt_en),
      .o_rreg0   (o_rreg0),
      .o_rreg1   (o_rreg1),
      .o_rd      (o_wreg0),
      .o_alu_op  (alu_op),
      .o_sub     (sub),
      .o_imm_sel (imm_sel),
      .o_is_lui  (is_lui),
      .o_wr_ok   (wr_ok),
      .o_imm_bit (imm_bit)
   );

   serv_alu alu (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_cnt_en  (cnt_en),
      .i_cnt0    (cnt0),
      .i_rs1     (i_rdata0),
      .i_rs2     (i_rdata1),
      .i_imm_bit (imm_bit),
      .i_alu_op  (alu_op),
      .i_sub     (sub),
      .i_imm_sel (imm_sel),
      .i_is_lui  (is_lui),
      .i_wr_ok   (wr_ok),
      .o_rd_bit  (o_wdata0),
      .o_wen     (o_wen0)
   );

   serv_ctrl ctrl (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_cnt_en   (cnt_en),
      .i_cnt0     (cnt0),
      .o_ibus_adr (o_ibus_adr)
   );

endmodule

// ==== dv/serv_tb.sv ====
`timescale 1ns/1ps
`include "serv_config.svh"

module serv_tb;

   localparam int HALF_PERIOD = 50;
   localparam int SETTLE = 20;
   localparam int TIMEOUT_CYCLES = 100;

   logic                    clk;
   logic                    rst_n;
   logic [`SERV_XLEN-1:0]   ibus_rdt;
   logic                    ibus_ack;
   logic                    rf_ready;
   logic                    rdata0;
   logic                    rdata1;
   wire  [`SERV_XLEN-1:0]   ibus_adr;
   wire                     ibus_cyc;
   wire                     rf_rreq;
   wire  [`SERV_REG_AW-1:0] rreg0;
   wire  [`SERV_REG_AW-1:0] rreg1;
   wire  [`SERV_REG_AW-1:0] wreg0;
   wire                     wen0;
   wire                     wdata0;

   int                      fd;
   int                      n_instr;
   string                   line;
   logic [31:0]             word;
   logic [31:0]             rs1_val;
   logic [31:0]             rs2_val;
   logic [31:0]             rd_exp;
   logic [31:0]             rd_got;
   logic [31:0]             pc_exp;
   logic                    wen_exp;

   serv_top serv_top_i (
      .i_clk      (clk),
      .i_rst_n    (rst_n),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .i_rf_ready (rf_ready),
      .i_rdata0   (rdata0),
      .i_rdata1   (rdata1),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .o_rf_rreq  (rf_rreq),
      .o_rreg0    (rreg0),
      .o_rreg1    (rreg1),
      .o_wreg0    (wreg0),
      .o_wen0     (wen0),
      .o_wdata0   (wdata0)
   );

   always #HALF_PERIOD clk = ~clk;

   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("sim failed");
      $fatal(1, "stopped at first failure");
   endtask

   task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         fail_stop($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
      end
   endtask

   // Only OP, OP-IMM with add/xor/or/and, and LUI write, never to x0
   function automatic logic expect_write(input logic [31:0] w);
      logic f3_ok;
      logic op_ok;
      case (w[14:12])
         3'b000, 3'b100, 3'b110, 3'b111: f3_ok = 1'b1;
         default: f3_ok = 1'b0;
      endcase
      case (w[6:0])
         7'h33, 7'h13: op_ok = f3_ok;
         7'h37: op_ok = 1'b1;
         default: op_ok = 1'b0;
      endcase
      return op_ok && (w[11:7] != 5'd0);
   endfunction

   task automatic wait_fetch();
      int cycles;
      cycles = 0;
      while (ibus_cyc !== 1'b1) begin
         if (cycles == TIMEOUT_CYCLES) begin
            fail_stop("Timed out waiting for the core to fetch an instruction");
         end
         @(negedge clk);
         cycles++;
      end
   endtask

   task automatic wait_rreq();
      int cycles;
      cycles = 0;
      while (rf_rreq !== 1'b1) begin
         if (cycles == TIMEOUT_CYCLES) begin
            fail_stop("Timed out waiting for the register file read request");
         end
         @(negedge clk);
         cycles++;
      end
   endtask

   // Ack delay from rs1[1:0], ready delay from rs2[1:0]
   task automatic run_instruction();
      wen_exp = expect_write(word);
      wait_fetch();
      check_eq("fetch address", ibus_adr, pc_exp);
      check_eq("rf_rreq during fetch", 32'(rf_rreq), 32'd0);
      check_eq("wen0 during fetch", 32'(wen0), 32'd0);
      repeat (rs1_val[1:0]) @(negedge clk);
      check_eq("ibus_cyc while ack held back", 32'(ibus_cyc), 32'd1);
      check_eq("fetch address while ack held back", ibus_adr, pc_exp);
      ibus_rdt = word;
      ibus_ack = 1'b1;
      @(negedge clk);
      ibus_ack = 1'b0;
      wait_rreq();
      repeat (rs2_val[1:0]) @(negedge clk);
      check_eq("rf_rreq while ready held back", 32'(rf_rreq), 32'd1);
      check_eq("rreg0", 32'(rreg0), 32'(word[19:15]));
      check_eq("rreg1", 32'(rreg1), 32'(word[24:20]));
      rf_ready = 1'b1;
      @(negedge clk);
      rf_ready = 1'b0;
      for (int k = 0; k < `SERV_XLEN; k++) begin
         rdata0 = rs1_val[k];
         rdata1 = rs2_val[k];
         #SETTLE;
         check_eq($sformatf("wen0 in run cycle %0d", k), 32'(wen0), 32'(wen_exp));
         check_eq("wreg0", 32'(wreg0), 32'(word[11:7]));
         rd_got[k] = wdata0;
         @(negedge clk);
      end
      check_eq("wen0 after the run", 32'(wen0), 32'd0);
      check_eq("ibus_cyc after the run", 32'(ibus_cyc), 32'd1);
      if (wen_exp) begin
         check_eq($sformatf("result of %h", word), rd_got, rd_exp);
      end
      pc_exp = pc_exp + 32'd4;
   endtask

   initial begin
      clk      = 1'b0;
      rst_n    = 1'b0;
      ibus_rdt = '0;
      ibus_ack = 1'b0;
      rf_ready = 1'b0;
      rdata0   = 1'b0;
      rdata1   = 1'b0;
      pc_exp   = `SERV_RESET_PC;
      n_instr  = 0;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      fd = $fopen("dv/serv_stim.txt", "r");
      if (fd == 0) begin
         fail_stop("Could not open dv/serv_stim.txt");
      end
      while ($fgets(line, fd) > 0) begin
         // Comment and blank lines give no fields
         if ($sscanf(line, "%h %h %h %h", word, rs1_val, rs2_val, rd_exp) == 4) begin
            run_instruction();
            n_instr++;
         end
      end
      $fclose(fd);
      if (n_instr == 0) begin
         fail_stop("The stim file held no instructions");
      end else begin
         $display("sim passed");
         $finish;
      end
   end

endmodule

// ==== dv/serv_stim.txt ====
# instr    rs1      rs2      rd       (all hex, one instruction per line)
# Low two bits of rs1 and rs2 set the ack and ready delays in cycles
002081B3 00000005 00000007 0000000C  add  x3, x1, x2
40628233 00000010 00000013 FFFFFFFD  sub  x4, x5, x6
009473B3 F0F0F0F2 FF00FF01 F000F000  and  x7, x8, x9
00C5E533 12340003 00005602 12345603  or   x10, x11, x12
00F746B3 AAAA5555 0F0F0F0F A5A55A5A  xor  x13, x14, x15
01DF0FB3 FFFFFFFF 00000002 00000001  add  x31, x30, x29 wraps
06410093 00000001 DEADBEEF 00000065  addi x1, x2, 100
FFF30293 00001000 12345678 00000FFF  addi x5, x6, -1
0F04F413 12345678 FFFFFFFF 00000070  andi x8, x9, 0xf0
80056493 00000123 00000001 FFFFF923  ori  x9, x10, -2048
FFF64593 0F0F0F0E 00000000 F0F0F0F1  xori x11, x12, -1
7FF6C613 00000801 00000003 00000FFE  xori x12, x13, 0x7ff
DEADB737 00000002 00000001 DEADB000  lui  x14, 0xdeadb
000017B7 00000000 00000002 00001000  lui  x15, 0x1
00208033 00000005 00000006 00000000  add  x0, x1, x2 writes nothing
00000013 00000003 00000001 00000000  nop
008000EF 00000001 00000002 00000000  jal  is unsupported
002091B3 00000002 00000003 00000000  sll  is unsupported
416A8A33 00000000 00000001 FFFFFFFF  sub  x20, x21, x22
800B0A93 80000000 00000002 7FFFF800  addi x21, x22, -2048

// ==== verilog.f ====
+incdir+design
design/serv_isa_pkg.sv
design/serv_core_pkg.sv
design/serv_decode.sv
design/serv_state.sv
design/serv_alu.sv
design/serv_ctrl.sv
design/serv_top.sv
dv/serv_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module serv_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vserv_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
   exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
